// File: Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= fe_tb
FILELIST  ?= fe_fetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SHELL := /bin/bash

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: fe_fetch.f
source/fe_pkg.sv
source/fe_pc_gen.sv
source/fe_imem.sv
source/fe_fetch_ctrl.sv
source/fe_top.sv
sim/fe_assertions.sv
sim/fe_tb.sv

// File: imem.hex
// 32-bit instruction words, one per line, ROM word 0 first
00500093
00a00113
002081b3
40110233
0041f2b3
0041e333
001193b3
0020d433
00c000ef
fe5ff06f
00112623
00c12483
00848513
00051463
00a50593
0045a023
0005a603
00c58693
fff68713
00e707b3
00478813
0107a8a3
01180913
0128f9b3
01298a33
01499ab3
00000b17
fdcb0b93
017b8c33
018c0cb3
00008067
0000006f

// File: sim/fe_assertions.sv
/*
  Protocol assertions for the fetch front end
  - queue valid low after reset
  - queue valid only with ready and never with a command
  - queue quiet after an exception until the next command
*/

module fe_assertions
  import fe_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      fe_cmd_v_i,
  input  fe_queue_s fe_queue_o,
  input  logic      fe_queue_v_o,
  input  logic      fe_queue_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic exc_xfer;
  logic exc_pending_r;

  assign exc_xfer = fe_queue_v_o & fe_queue_ready_i & (fe_queue_o.msg_type == e_fe_exception);

  // Set by an exception transfer, cleared by the next command
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      exc_pending_r <= 1'b0;
    else
      exc_pending_r <= ~fe_cmd_v_i & (exc_pending_r | exc_xfer);
  end

  a_quiet_after_reset: assert property (@(posedge clk_i) reset_i |=> !fe_queue_v_o)
    else $error("queue valid raised right after reset");

  a_valid_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_queue_v_o |-> fe_queue_ready_i)
    else $error("queue valid raised without ready");

  a_no_valid_with_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_queue_v_o |-> !fe_cmd_v_i)
    else $error("queue valid raised together with a command");

  a_quiet_after_exception: assert property (@(posedge clk_i) disable iff (reset_i)
    exc_pending_r |-> !fe_queue_v_o)
    else $error("queue valid raised after an exception with no command");

endmodule

bind fe_top fe_assertions u_fe_assertions (.*);

// File: sim/fe_tb.sv
/*
  Testbench for the fetch front end
  - clock, reset and falling-edge stimulus
  - reference model of the message stream built from the ROM image
  - directed tests, a seeded random test, watchdog and summary
*/

module fe_tb
  import fe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 5;
  localparam int IDLE_CYCLES     = 20;
  localparam int WAIT_LIMIT      = 40;
  localparam int STALL_LIMIT     = 8;
  localparam int DIRECTED_CYCLES = 7 * (WAIT_LIMIT + 20);
  localparam int RAND_CYCLES     = 4000;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + IDLE_CYCLES + DIRECTED_CYCLES + RAND_CYCLES;
  localparam int ROM_BYTES       = IMEM_WORDS * 4;
  localparam int CHECK_WIDTH     = $bits(fe_queue_s);

  logic      clk_i;
  logic      reset_i;
  fe_cmd_s   fe_cmd_i;
  logic      fe_cmd_v_i;
  fe_queue_s fe_queue_o;
  logic      fe_queue_v_o;
  logic      fe_queue_ready_i;

  // Model state, updated at each rising edge
  logic [INSTR_WIDTH-1:0] rom_model [IMEM_WORDS];
  logic [VADDR_WIDTH-1:0] exp_pc      = '0;
  logic                   stream_open = 1'b0;
  integer                 seed        = 32'hbf25_fbc7;
  int                     errors      = 0;
  int                     checks      = 0;
  int                     xfer_count  = 0;
  int                     cycle_cnt   = 0;
  int                     cmd_cycle   = 0;
  int                     first_lat   = -1;
  int                     idle_streak = 0;
  int                     test_errors = 0;
  int                     test_xfers  = 0;
  int                     mark        = 0;
  string                  cur_test    = "reset";

  fe_top u_fe_top
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_i         (fe_cmd_i),
    .fe_cmd_v_i       (fe_cmd_v_i),
    .fe_queue_o       (fe_queue_o),
    .fe_queue_v_o     (fe_queue_v_o),
    .fe_queue_ready_i (fe_queue_ready_i)
  );

  always
  begin
    #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [CHECK_WIDTH-1:0] expected,
                             input logic [CHECK_WIDTH-1:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // Misaligned wins over access fault, fetches read word pc/4
  function automatic fe_queue_s expected_msg(input logic [VADDR_WIDTH-1:0] pc);
    fe_queue_s m;
    m    = '0;
    m.pc = pc;
    if (pc[1:0] != 2'b00)
    begin
      m.msg_type = e_fe_exception;
      m.exc_code = e_instr_misaligned;
    end
    else if (pc >= ROM_BYTES)
    begin
      m.msg_type = e_fe_exception;
      m.exc_code = e_instr_access_fault;
    end
    else
    begin
      m.msg_type = e_fe_fetch;
      m.instr    = rom_model[pc[2 +: IMEM_IDX_WIDTH]];
      m.exc_code = e_none;
    end
    return m;
  endfunction

  task automatic check_transfer();
    fe_queue_s expected;
    xfer_count++;
    if (first_lat < 0)
      first_lat = cycle_cnt - cmd_cycle;
    if (!stream_open)
    begin
      errors++;
      $display("test %s: a message was sent while no command was pending", cur_test);
    end
    else
    begin
      expected = expected_msg(exp_pc);
      check_value(cur_test, expected, fe_queue_o);
      if (expected.msg_type == e_fe_exception)
        stream_open = 1'b0;
      else
        exp_pc = exp_pc + 32'd4;
    end
  endtask

  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      cycle_cnt++;
      if (fe_queue_v_o && fe_queue_ready_i)
      begin
        idle_streak = 0;
        check_transfer();
      end
      else if (stream_open && fe_queue_ready_i && !fe_cmd_v_i)
      begin
        // An open stream with ready high must keep producing messages
        idle_streak++;
        if (idle_streak == STALL_LIMIT)
        begin
          errors++;
          $display("test %s: no message for %0d cycles with ready high",
                   cur_test, STALL_LIMIT);
        end
      end
      else
      begin
        idle_streak = 0;
      end
      if (fe_cmd_v_i)
      begin
        exp_pc      = fe_cmd_i.vaddr;
        stream_open = 1'b1;
        cmd_cycle   = cycle_cnt;
        first_lat   = -1;
      end
    end
  end

  task automatic step(input logic cmd_v, input fe_opcode_e op,
                      input logic [VADDR_WIDTH-1:0] vaddr, input logic ready);
    @(negedge clk_i);
    fe_cmd_v_i       = cmd_v;
    fe_cmd_i.opcode  = op;
    fe_cmd_i.vaddr   = vaddr;
    fe_queue_ready_i = ready;
  endtask

  task automatic run_idle(input int cycles);
    repeat (cycles) step(1'b0, e_op_pc_redirect, '0, 1'b1);
  endtask

  // Returns once the command has been sampled
  task automatic send_cmd(input fe_opcode_e op, input logic [VADDR_WIDTH-1:0] vaddr);
    step(1'b1, op, vaddr, 1'b1);
    step(1'b0, e_op_pc_redirect, '0, 1'b1);
  endtask

  task automatic await_message();
    int n;
    n = 0;
    while (first_lat < 0 && n < WAIT_LIMIT)
    begin
      step(1'b0, e_op_pc_redirect, '0, 1'b1);
      n++;
    end
    if (first_lat < 0)
    begin
      errors++;
      $display("test %s: no message arrived after the command", cur_test);
    end
  endtask

  task automatic await_exception();
    int n;
    n = 0;
    while (stream_open && n < WAIT_LIMIT)
    begin
      step(1'b0, e_op_pc_redirect, '0, 1'b1);
      n++;
    end
    if (stream_open)
    begin
      errors++;
      $display("test %s: the exception message did not arrive", cur_test);
    end
  endtask

  function automatic logic [VADDR_WIDTH-1:0] random_vaddr();
    int                     sel;
    logic [VADDR_WIDTH-1:0] addr;
    sel = {$random(seed)} % 16;
    if (sel < 10)
      addr = ({$random(seed)} % IMEM_WORDS) * 4;
    else if (sel < 12)
      addr = ROM_BYTES - (({$random(seed)} % 4) + 1) * 4;
    else if (sel < 14)
    begin
      addr = {$random(seed)} % ROM_BYTES;
      if (addr[1:0] == 2'b00)
        addr = addr + 32'd2;
    end
    else
      addr = ROM_BYTES + ({$random(seed)} % 64) * 4;
    return addr;
  endfunction

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = errors;
    test_xfers  = xfer_count;
  endtask

  task automatic end_test();
    $display("test %s: %s, %0d messages", cur_test,
             (errors == test_errors) ? "ok" : "failed", xfer_count - test_xfers);
  endtask

  initial
  begin
    logic       cmd_v;
    logic       ready;
    fe_opcode_e op;
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    fe_cmd_i         = '0;
    fe_cmd_v_i       = 1'b0;
    fe_queue_ready_i = 1'b1;
    $readmemh(IMEM_FILE, rom_model);
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    begin_test("reset_idle");
    run_idle(IDLE_CYCLES);
    check_value(cur_test, CHECK_WIDTH'(0), CHECK_WIDTH'(xfer_count - test_xfers));
    end_test();

    begin_test("redirect_latency");
    send_cmd(e_op_pc_redirect, 32'd0);
    await_message();
    check_value(cur_test, CHECK_WIDTH'(2), CHECK_WIDTH'(first_lat));
    run_idle(12);
    end_test();

    // 112 to 124 fetch, then 128 faults
    begin_test("rom_end");
    send_cmd(e_op_pc_redirect, 32'd112);
    mark = xfer_count;
    await_exception();
    run_idle(10);
    check_value(cur_test, CHECK_WIDTH'((ROM_BYTES - 112) / 4 + 1), CHECK_WIDTH'(xfer_count - mark));
    end_test();

    begin_test("misaligned");
    send_cmd(e_op_pc_redirect, 32'h46);
    mark = xfer_count;
    await_exception();
    run_idle(8);
    check_value(cur_test, CHECK_WIDTH'(1), CHECK_WIDTH'(xfer_count - mark));
    end_test();

    begin_test("out_of_range");
    send_cmd(e_op_pc_redirect, 32'h200);
    mark = xfer_count;
    await_exception();
    run_idle(8);
    check_value(cur_test, CHECK_WIDTH'(1), CHECK_WIDTH'(xfer_count - mark));
    end_test();

    begin_test("fence");
    send_cmd(e_op_pc_redirect, 32'd0);
    run_idle(6);
    send_cmd(e_op_fence, 32'h40);
    await_message();
    check_value(cur_test, CHECK_WIDTH'(1), CHECK_WIDTH'(first_lat >= 3));
    run_idle(6);
    end_test();

    begin_test("midstream");
    send_cmd(e_op_pc_redirect, 32'h10);
    run_idle(5);
    send_cmd(e_op_pc_redirect, 32'h60);
    await_message();
    check_value(cur_test, CHECK_WIDTH'(2), CHECK_WIDTH'(first_lat));
    run_idle(6);
    end_test();

    begin_test("random");
    for (int i = 0; i < RAND_CYCLES; i++)
    begin
      cmd_v = ({$random(seed)} % 20) == 0;
      ready = ({$random(seed)} % 4) != 0;
      op    = (($random(seed) & 1) != 0) ? e_op_fence : e_op_pc_redirect;
      step(cmd_v, op, random_vaddr(), ready);
    end
    run_idle(4);
    end_test();

    $display("summary: %0d checks, %0d errors, %0d messages", checks, errors, xfer_count);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    #(TOTAL_CYCLES * CLK_PERIOD * 2);
    $display("timeout: the tests did not finish within %0d ns", TOTAL_CYCLES * CLK_PERIOD * 2);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: source/fe_fetch_ctrl.sv
/*
  Fetch controller
  - command decode into redirect and fence
  - wait/run/stall state machine and IF1/IF2 valid bits
  - resume pc for replay after back-pressure or fence
  - queue message formation with exception priority
*/

module fe_fetch_ctrl
  import fe_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  fe_cmd_s                cmd_i,
  input  logic                   cmd_v_i,
  input  logic                   queue_ready_i,

  input  logic [VADDR_WIDTH-1:0] if2_pc_i,
  input  logic [INSTR_WIDTH-1:0] instr_i,
  input  logic                   misaligned_i,
  input  logic                   access_fault_i,

  output fe_queue_s              queue_o,
  output logic                   queue_v_o,

  output logic                   redirect_v_o,
  output logic [VADDR_WIDTH-1:0] redirect_pc_o,
  output logic                   advance_o
);

  fe_state_e              state_r;
  fe_state_e              state_n;
  logic                   is_run;
  logic                   is_stall;

  logic                   redirect_cmd_v;
  logic                   fence_cmd_v;

  logic                   v_if1_r;
  logic                   v_if2_r;
  logic                   v_if2_n;

  logic                   exception_v;
  logic                   queue_miss;
  logic                   fetch_fail;
  logic                   exception_xfer;
  logic                   unstall;

  logic [VADDR_WIDTH-1:0] pc_resume_r;

  assign is_run   = (state_r == e_run);
  assign is_stall = (state_r == e_stall);

  assign redirect_cmd_v = cmd_v_i & (cmd_i.opcode == e_op_pc_redirect);
  assign fence_cmd_v    = cmd_v_i & (cmd_i.opcode == e_op_fence);

  assign exception_v = v_if2_r & (misaligned_i | access_fault_i);
  assign queue_miss  = v_if2_r & ~queue_ready_i;

  // A command in the same cycle takes precedence over the IF2 result
  assign queue_v_o      = queue_ready_i & v_if2_r & ~cmd_v_i;
  assign fetch_fail     = v_if2_r & ~queue_v_o;
  assign exception_xfer = queue_v_o & exception_v;
  assign unstall        = queue_ready_i & ~cmd_v_i;

  always_comb
  begin
    case (state_r)
      e_wait:
      begin
        if (redirect_cmd_v)
          state_n = e_run;
        else if (fence_cmd_v)
          state_n = e_stall;
        else
          state_n = e_wait;
      end
      e_stall:
      begin
        if (redirect_cmd_v || (!fence_cmd_v && unstall))
          state_n = e_run;
        else
          state_n = e_stall;
      end
      e_run:
      begin
        // Redirect restarts in place, fence or lost fetch replays later
        if (redirect_cmd_v)
          state_n = e_run;
        else if (fence_cmd_v || fetch_fail)
          state_n = e_stall;
        else if (exception_xfer)
          state_n = e_wait;
        else
          state_n = e_run;
      end
      default:
      begin
        state_n = e_wait;
      end
    endcase
  end

  assign advance_o     = (state_n == e_run);
  assign redirect_v_o  = redirect_cmd_v | (is_stall & advance_o);
  assign redirect_pc_o = cmd_v_i ? cmd_i.vaddr : pc_resume_r;

  // Anything younger than a command, a lost fetch or an exception is dropped
  assign v_if2_n = v_if1_r & ~(cmd_v_i | queue_miss | exception_v);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_wait;
      v_if1_r <= 1'b0;
      v_if2_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      v_if1_r <= advance_o;
      v_if2_r <= v_if2_n;
    end
  end

  // Command vaddr on a command, else the IF2 pc while running
  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
    begin
      pc_resume_r <= cmd_i.vaddr;
    end
    else if (is_run)
    begin
      pc_resume_r <= if2_pc_i;
    end
  end

  always_comb
  begin
    queue_o    = '0;
    queue_o.pc = if2_pc_i;
    if (misaligned_i)
    begin
      queue_o.msg_type = e_fe_exception;
      queue_o.exc_code = e_instr_misaligned;
    end
    else if (access_fault_i)
    begin
      queue_o.msg_type = e_fe_exception;
      queue_o.exc_code = e_instr_access_fault;
    end
    else
    begin
      queue_o.msg_type = e_fe_fetch;
      queue_o.instr    = instr_i;
      queue_o.exc_code = e_none;
    end
  end

endmodule

// File: source/fe_imem.sv
/*
  Instruction ROM of the fetch front end
  - contents loaded from the ROM data file
  - IF1 read register and IF2 output register
  - misaligned and access fault flags carried with the data
*/

module fe_imem
  import fe_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  logic                   read_v_i,
  input  logic [VADDR_WIDTH-1:0] read_pc_i,

  output logic [INSTR_WIDTH-1:0] instr_o,
  output logic                   misaligned_o,
  output logic                   access_fault_o
);

  logic [INSTR_WIDTH-1:0]    rom [IMEM_WORDS];
  logic [IMEM_IDX_WIDTH-1:0] read_idx;
  logic                      read_misaligned;
  logic                      read_fault;

  logic [INSTR_WIDTH-1:0]    if1_instr_r;
  logic [INSTR_WIDTH-1:0]    if2_instr_r;
  logic                      if1_misaligned_r;
  logic                      if1_fault_r;
  logic                      if2_misaligned_r;
  logic                      if2_fault_r;

  initial
  begin
    $readmemh(IMEM_FILE, rom);
  end

  // Word index sits above the byte offset
  assign read_idx        = read_pc_i[$clog2(INSTR_BYTES) +: IMEM_IDX_WIDTH];
  assign read_misaligned = |read_pc_i[$clog2(INSTR_BYTES)-1:0];
  assign read_fault      = (read_pc_i >= VADDR_WIDTH'(IMEM_WORDS * INSTR_BYTES));

  always_ff @(posedge clk_i)
  begin
    if (read_v_i)
    begin
      if1_instr_r <= rom[read_idx];
      if2_instr_r <= if1_instr_r;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      if1_misaligned_r <= 1'b0;
      if1_fault_r      <= 1'b0;
      if2_misaligned_r <= 1'b0;
      if2_fault_r      <= 1'b0;
    end
    else if (read_v_i)
    begin
      if1_misaligned_r <= read_misaligned;
      if1_fault_r      <= read_fault;
      if2_misaligned_r <= if1_misaligned_r;
      if2_fault_r      <= if1_fault_r;
    end
  end

  assign instr_o        = if2_instr_r;
  assign misaligned_o   = if2_misaligned_r;
  assign access_fault_o = if2_fault_r;

endmodule

// File: source/fe_pc_gen.sv
/*
  PC generator for the two-stage fetch pipeline
  - next pc selection between redirect and sequential
  - IF1 and IF2 pc registers shifted on advance
*/

module fe_pc_gen
  import fe_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  logic                   redirect_v_i,
  input  logic [VADDR_WIDTH-1:0] redirect_pc_i,
  input  logic                   advance_i,

  output logic [VADDR_WIDTH-1:0] next_pc_o,
  output logic [VADDR_WIDTH-1:0] if2_pc_o
);

  logic [VADDR_WIDTH-1:0] if1_pc_r;
  logic [VADDR_WIDTH-1:0] if2_pc_r;
  logic [VADDR_WIDTH-1:0] seq_pc;

  // Sequential successor of the pc currently in IF1
  assign seq_pc = if1_pc_r + VADDR_WIDTH'(INSTR_BYTES);

  always_comb
  begin
    if (redirect_v_i)
    begin
      next_pc_o = redirect_pc_i;
    end
    else
    begin
      next_pc_o = seq_pc;
    end
  end

  // Both stages move together, so up to two fetches are in flight
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      if1_pc_r <= '0;
      if2_pc_r <= '0;
    end
    else if (advance_i)
    begin
      if1_pc_r <= next_pc_o;
      if2_pc_r <= if1_pc_r;
    end
  end

  assign if2_pc_o = if2_pc_r;

endmodule

// File: source/fe_pkg.sv
/*
  Shared definitions for the fetch front end
  - sizes of pc, instruction and instruction ROM
  - command opcodes and the command struct
  - queue message kinds, exception codes and the queue struct
  - controller state encoding
*/

package fe_pkg;

  localparam int VADDR_WIDTH    = 32;
  localparam int INSTR_WIDTH    = 32;
  localparam int INSTR_BYTES    = 4;

  // ROM covers byte addresses 0 to IMEM_WORDS*INSTR_BYTES-1
  localparam int IMEM_WORDS     = 32;
  localparam int IMEM_IDX_WIDTH = 5;
  localparam string IMEM_FILE   = "imem.hex";

  typedef enum logic
  {
    e_op_pc_redirect = 1'b0,
    e_op_fence       = 1'b1
  } fe_opcode_e;

  typedef struct packed
  {
    fe_opcode_e             opcode;
    logic [VADDR_WIDTH-1:0] vaddr;
  } fe_cmd_s;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  typedef enum logic [1:0]
  {
    e_instr_misaligned   = 2'd0,
    e_instr_access_fault = 2'd1,
    e_none               = 2'd2
  } fe_exc_code_e;

  // instr is zero for exceptions, exc_code is e_none for fetches
  typedef struct packed
  {
    fe_msg_type_e           msg_type;
    logic [VADDR_WIDTH-1:0] pc;
    logic [INSTR_WIDTH-1:0] instr;
    fe_exc_code_e           exc_code;
  } fe_queue_s;

  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

endpackage

// File: source/fe_top.sv
/*
  Fetch front end top level
  - fetch controller, pc generator and instruction ROM
  - command input and fetch queue output ports
*/

module fe_top
  import fe_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  fe_cmd_s   fe_cmd_i,
  input  logic      fe_cmd_v_i,

  output fe_queue_s fe_queue_o,
  output logic      fe_queue_v_o,
  input  logic      fe_queue_ready_i
);

  logic                   redirect_v;
  logic [VADDR_WIDTH-1:0] redirect_pc;
  logic                   advance;
  logic [VADDR_WIDTH-1:0] next_pc;
  logic [VADDR_WIDTH-1:0] if2_pc;
  logic [INSTR_WIDTH-1:0] instr;
  logic                   misaligned;
  logic                   access_fault;

  fe_fetch_ctrl u_fetch_ctrl
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cmd_i          (fe_cmd_i),
    .cmd_v_i        (fe_cmd_v_i),
    .queue_ready_i  (fe_queue_ready_i),
    .if2_pc_i       (if2_pc),
    .instr_i        (instr),
    .misaligned_i   (misaligned),
    .access_fault_i (access_fault),
    .queue_o        (fe_queue_o),
    .queue_v_o      (fe_queue_v_o),
    .redirect_v_o   (redirect_v),
    .redirect_pc_o  (redirect_pc),
    .advance_o      (advance)
  );

  fe_pc_gen u_pc_gen
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .redirect_v_i  (redirect_v),
    .redirect_pc_i (redirect_pc),
    .advance_i     (advance),
    .next_pc_o     (next_pc),
    .if2_pc_o      (if2_pc)
  );

  // ROM reads at the pc entering IF1
  fe_imem u_imem
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .read_v_i       (advance),
    .read_pc_i      (next_pc),
    .instr_o        (instr),
    .misaligned_o   (misaligned),
    .access_fault_o (access_fault)
  );

endmodule
